//--- bench/tb_programs.svh
// Programs are built at time zero, one word per put call
localparam int PROG_COUNT = 5;
localparam int PROG_MAX   = 16;

string prog_name [PROG_COUNT] = '{"alu_chain", "load_use", "control_flow", "status", "io_port"};
int prog_len [PROG_COUNT];
logic [31:0] prog_words [PROG_COUNT][PROG_MAX];

// R-type: rd = rs op rt, shamt for shifts
function automatic logic [31:0] rw(input alu_op_e fn, input int rd, input int rs,
		input int rt, input int sh);
	return {OP_ALU, 5'(rd), 5'(rs), 5'(rt), 5'(sh), 1'b0, fn, 2'b00};
endfunction

// I-type, 17-bit immediate in the low bits
function automatic logic [31:0] iw(input opcode_e op, input int rd, input int rs, input int imm);
	return {op, 5'(rd), 5'(rs), 17'(imm)};
endfunction

// J-type, 27-bit target
function automatic logic [31:0] jw(input opcode_e op, input int target);
	return {op, 27'(target)};
endfunction

task automatic put(input int p, input logic [31:0] word);
	prog_words[p][prog_len[p]] = word;
	prog_len[p]++;
endtask

task automatic build_programs();
	for (int p = 0; p < PROG_COUNT; p++)
		prog_len[p] = 0;

	// Dependent chain, both forwarding paths
	put(0, iw(OP_ADDI, 1, 0, 5));
	put(0, iw(OP_ADDI, 2, 1, 7));
	put(0, rw(ALU_ADD, 3, 1, 2, 0));
	put(0, rw(ALU_SUB, 4, 3, 1, 0));
	put(0, rw(ALU_SLL, 5, 4, 0, 3));
	put(0, iw(OP_ADDI, 6, 0, -64));
	put(0, rw(ALU_SRA, 7, 6, 0, 2));
	put(0, rw(ALU_AND, 8, 5, 3, 0));
	put(0, rw(ALU_OR, 9, 8, 7, 0));
	put(0, rw(ALU_SLT, 10, 7, 1, 0));
	put(0, iw(OP_SW, 10, 0, 6));
	put(0, iw(OP_SW, 3, 0, 1));
	put(0, iw(OP_SW, 4, 0, 2));
	put(0, iw(OP_SW, 5, 0, 3));
	put(0, iw(OP_SW, 7, 0, 4));
	put(0, iw(OP_SW, 9, 0, 5));

	// Loads followed at once by their use
	put(1, iw(OP_ADDI, 1, 0, 4660));
	put(1, iw(OP_SW, 1, 0, 10));
	put(1, iw(OP_LW, 2, 0, 10));
	put(1, iw(OP_ADDI, 3, 2, 1));
	put(1, iw(OP_SW, 3, 0, 11));
	put(1, iw(OP_LW, 4, 0, 11));
	put(1, iw(OP_SW, 4, 0, 12));
	put(1, iw(OP_LW, 5, 0, 10));
	put(1, rw(ALU_ADD, 6, 5, 4, 0));
	put(1, iw(OP_SW, 6, 0, 13));

	// Taken and untaken branches, jal, jr, j
	put(2, iw(OP_ADDI, 1, 0, 3));
	put(2, iw(OP_ADDI, 2, 0, 3));
	put(2, iw(OP_BEQ, 1, 2, 1));
	put(2, iw(OP_SW, 1, 0, 20));
	put(2, iw(OP_BNE, 1, 2, 1));
	put(2, iw(OP_SW, 1, 0, 21));
	put(2, iw(OP_ADDI, 3, 0, -2));
	put(2, iw(OP_BLT, 3, 1, 1));
	put(2, iw(OP_SW, 3, 0, 22));
	put(2, iw(OP_BLT, 1, 3, 1));
	put(2, jw(OP_JAL, 13));
	put(2, iw(OP_SW, 1, 0, 23));
	put(2, jw(OP_J, 16));
	put(2, iw(OP_SW, 31, 0, 24));
	put(2, iw(OP_JR, 31, 0, 0));
	put(2, iw(OP_SW, 2, 0, 25));

	// bex falls through on zero status, jumps after setx
	put(3, jw(OP_BEX, 3));
	put(3, iw(OP_ADDI, 1, 0, 1));
	put(3, iw(OP_SW, 1, 0, 30));
	put(3, jw(OP_SETX, 7));
	put(3, jw(OP_BEX, 7));
	put(3, iw(OP_ADDI, 1, 0, 99));
	put(3, iw(OP_SW, 1, 0, 31));
	put(3, iw(OP_ADDI, 2, 0, 2));
	put(3, iw(OP_SW, 2, 0, 32));

	put(4, iw(OP_IN, 1, 0, 0));
	put(4, iw(OP_SW, 1, 0, 255));
	put(4, iw(OP_ADDI, 2, 1, 1));
	put(4, iw(OP_SW, 2, 0, 40));
endtask

//--- bench/processor_tb.sv
`timescale 1ns/1ps

module processor_tb import cpu_pkg::*; ();

	`include "tb_programs.svh"

	typedef struct packed {
		logic [7:0]  addr;
		logic [31:0] data;
	} store_t;

	localparam int WATCH_CYCLES = PROG_COUNT * (40 * PROG_MAX + IMEM_WORDS + 60);

	logic        clock;
	logic        rst_n;
	logic        run;
	logic        prog_we;
	logic [7:0]  prog_addr;
	logic [31:0] prog_data;
	logic [7:0]  in_data;
	logic        mem_wr;
	logic [7:0]  mem_addr;
	logic [31:0] mem_wdata;
	logic        out_valid;
	logic [31:0] out_data;

	logic [31:0] img [IMEM_WORDS];
	store_t      exp_q [$];
	string       cur_name = "reset";
	logic        idle_check = 1'b1;
	logic        io_pend = 1'b0;
	logic [31:0] io_exp;
	logic [31:0] rng = 32'h8b35_b1bd;
	int          errors = 0;
	int          checks = 0;

	processor processor_inst (
		.clock     (clock),
		.rst_n     (rst_n),
		.run       (run),
		.prog_we   (prog_we),
		.prog_addr (prog_addr),
		.prog_data (prog_data),
		.in_data   (in_data),
		.mem_wr    (mem_wr),
		.mem_addr  (mem_addr),
		.mem_wdata (mem_wdata),
		.out_valid (out_valid),
		.out_data  (out_data)
	);

	initial begin
		clock = 1'b0;
		forever #4 clock = ~clock;
	end

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		return y ^ (y << 5);
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Reference ISA model, one instruction at a time
	//////////////////////////////////////////////////////////////////////

	task automatic run_model();
		logic [31:0] regs [32];
		logic [31:0] dm [256];
		logic [31:0] w, v_rd, v_rs, v_rt, imm, pc, npc, addr, status_m;
		store_t s;
		int steps;
		for (int i = 0; i < 32; i++)
			regs[i] = '0;
		for (int i = 0; i < 256; i++)
			dm[i] = '0;
		pc = '0;
		status_m = '0;
		steps = 0;
		// A jump to itself ends the program
		while (img[pc[7:0]] != {OP_J, 27'(pc)} && steps < 200) begin
			w    = img[pc[7:0]];
			v_rd = regs[w[26:22]];
			v_rs = regs[w[21:17]];
			v_rt = regs[w[16:12]];
			imm  = {{15{w[16]}}, w[16:0]};
			addr = v_rs + imm;
			npc  = pc + 1;
			case (w[31:27])
				OP_ALU: begin
					case (w[6:2])
						5'd0: regs[w[26:22]] = v_rs + v_rt;
						5'd1: regs[w[26:22]] = v_rs - v_rt;
						5'd2: regs[w[26:22]] = v_rs & v_rt;
						5'd3: regs[w[26:22]] = v_rs | v_rt;
						5'd4: regs[w[26:22]] = v_rs << w[11:7];
						5'd5: regs[w[26:22]] = $signed(v_rs) >>> w[11:7];
						5'd6: regs[w[26:22]] = {31'b0, $signed(v_rs) < $signed(v_rt)};
						default: ;
					endcase
				end
				OP_ADDI: regs[w[26:22]] = addr;
				OP_LW:   regs[w[26:22]] = dm[addr[7:0]];
				OP_SW: begin
					dm[addr[7:0]] = v_rd;
					s.addr = addr[7:0];
					s.data = v_rd;
					exp_q.push_back(s);
				end
				OP_BEQ: if (v_rd == v_rs) npc = pc + 1 + imm;
				OP_BNE: if (v_rd != v_rs) npc = pc + 1 + imm;
				OP_BLT: if ($signed(v_rd) < $signed(v_rs)) npc = pc + 1 + imm;
				OP_J:   npc = {5'b0, w[26:0]};
				OP_JAL: begin
					regs[31] = pc + 1;
					npc = {5'b0, w[26:0]};
				end
				OP_JR:   npc = v_rd;
				OP_SETX: status_m = {5'b0, w[26:0]};
				OP_BEX:  if (status_m != '0) npc = {5'b0, w[26:0]};
				OP_IN:   regs[w[26:22]] = {24'b0, in_data};
				default: ;
			endcase
			regs[0] = '0;
			pc = npc;
			steps++;
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Checkers
	//////////////////////////////////////////////////////////////////////

	assert property (@(posedge clock) idle_check |-> (!mem_wr && !out_valid))
	else begin
		$display("Store or output strobe while the core is idle or in reset (%s)", cur_name);
		errors++;
	end

	always @(posedge clock) begin
		// Output port strobe one cycle after the store to IO_ADDR
		if (io_pend) begin
			assert (out_valid)
			else begin
				$display("No out_valid after the store to the I/O address in %s", cur_name);
				errors++;
			end
			assert (out_data == io_exp)
			else begin
				$display("MISMATCH %s out_data: expected %h, actual %h",
					cur_name, io_exp, out_data);
				errors++;
			end
		end else begin
			assert (!out_valid)
			else begin
				$display("out_valid raised without an I/O store in %s", cur_name);
				errors++;
			end
		end
		io_pend = 1'b0;

		if (rst_n && mem_wr) begin
			checks++;
			assert (exp_q.size() != 0)
			else begin
				$display("Store to %0d in %s that the program never makes", mem_addr, cur_name);
				errors++;
			end
			if (exp_q.size() != 0) begin
				assert (mem_addr == exp_q[0].addr && mem_wdata == exp_q[0].data)
				else begin
					$display("MISMATCH %s store: expected [%0d]=%h, actual [%0d]=%h",
						cur_name, exp_q[0].addr, exp_q[0].data, mem_addr, mem_wdata);
					errors++;
				end
				if (exp_q[0].addr == 8'(IO_ADDR)) begin
					io_pend = 1'b1;
					io_exp  = exp_q[0].data;
				end
				void'(exp_q.pop_front());
			end
		end
	end

	initial begin
		#(WATCH_CYCLES * 8);
		$display("Timeout: the run did not finish within %0d cycles", WATCH_CYCLES);
		$display("TEST RESULT: FAIL");
		$finish;
	end

	//////////////////////////////////////////////////////////////////////
	// Main sequence
	//////////////////////////////////////////////////////////////////////

	initial begin
		int wait_cycles;
		rst_n     = 1'b0;
		run       = 1'b0;
		prog_we   = 1'b0;
		prog_addr = '0;
		prog_data = '0;
		in_data   = '0;
		build_programs();

		for (int p = 0; p < PROG_COUNT; p++) begin
			@(negedge clock);
			run = 1'b0;
			repeat (2) @(negedge clock);
			idle_check = 1'b1;
			cur_name = prog_name[p];
			rst_n = 1'b0;
			repeat (10) @(negedge clock);
			rst_n = 1'b1;

			// Unused words jump to themselves
			for (int i = 0; i < IMEM_WORDS; i++)
				img[i] = (i < prog_len[p]) ? prog_words[p][i] : {OP_J, 27'(i)};
			for (int i = 0; i < IMEM_WORDS; i++) begin
				prog_we   = 1'b1;
				prog_addr = 8'(i);
				prog_data = img[i];
				@(negedge clock);
			end
			prog_we = 1'b0;

			rng = xorshift(rng);
			in_data = rng[7:0];
			exp_q.delete();
			run_model();

			idle_check = 1'b0;
			run = 1'b1;
			wait_cycles = 0;
			while (exp_q.size() != 0 && wait_cycles < 40 * prog_len[p]) begin
				@(negedge clock);
				wait_cycles++;
			end
			assert (exp_q.size() == 0)
			else begin
				$display("%0d expected stores never appeared in %s", exp_q.size(), cur_name);
				errors++;
			end
			// Room for any stray store from a flushed path
			repeat (30) @(negedge clock);
		end

		$display("Stores checked: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

//--- processor.f
+incdir+bench
source/cpu_pkg.sv
source/alu.sv
source/reg_file.sv
source/instr_decoder.sv
source/hazard_unit.sv
source/processor.sv
bench/processor_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the processor testbench with Verilator

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing --assert -f processor.f --top-module processor_tb -o processor_sim
if [ $? -ne 0 ]; then
	echo "Verilator compile failed"
	exit 1
fi

./obj_dir/processor_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "^TEST RESULT: PASS$" sim.log; then
	exit 0
fi
echo "Pass message not found in sim.log"
exit 1

//--- source/alu.sv
`timescale 1ns/1ps

module alu import cpu_pkg::*; (
	input  logic [XLEN-1:0] operand_a,
	input  logic [XLEN-1:0] operand_b,
	input  alu_op_e         alu_op,
	input  logic [4:0]      shamt,
	output logic [XLEN-1:0] result,
	output logic            less_than,
	output logic            not_equal
);

	logic [XLEN-1:0] sum;
	logic [XLEN-1:0] diff;

	assign sum  = operand_a + operand_b;
	assign diff = operand_a - operand_b;

	// Signed compare, shared by slt and blt
	assign less_than = $signed(operand_a) < $signed(operand_b);
	assign not_equal = |diff;

	always_comb begin
		case (alu_op)
			ALU_ADD: begin
				result = sum;
			end
			ALU_SUB: begin
				result = diff;
			end
			ALU_AND: begin
				result = operand_a & operand_b;
			end
			ALU_OR: begin
				result = operand_a | operand_b;
			end
			ALU_SLL: begin
				result = operand_a << shamt;
			end
			ALU_SRA: begin
				result = $unsigned($signed(operand_a) >>> shamt);
			end
			ALU_SLT: begin
				result = {{(XLEN-1){1'b0}}, less_than};
			end
			default: begin
				result = '0;
			end
		endcase
	end

endmodule

//--- source/cpu_pkg.sv
package cpu_pkg;

	//////////////////////////////////////////////////////////////////////
	// Sizes
	//////////////////////////////////////////////////////////////////////

	localparam int XLEN       = 32;
	localparam int IMEM_WORDS = 256;
	localparam int DMEM_WORDS = 256;
	localparam int IMEM_AW    = $clog2(IMEM_WORDS);
	localparam int DMEM_AW    = $clog2(DMEM_WORDS);
	localparam int REG_W      = 5;

	// Word address of the output port
	localparam int IO_ADDR = 255;

	// jal writes its return address here
	localparam logic [REG_W-1:0] LINK_REG = 5'd31;

	//////////////////////////////////////////////////////////////////////
	// Encodings
	//////////////////////////////////////////////////////////////////////

	typedef enum logic [4:0] {
		OP_ALU  = 5'd0,
		OP_ADDI = 5'd1,
		OP_LW   = 5'd2,
		OP_SW   = 5'd3,
		OP_BEQ  = 5'd4,
		OP_BNE  = 5'd5,
		OP_BLT  = 5'd6,
		OP_J    = 5'd7,
		OP_JAL  = 5'd8,
		OP_JR   = 5'd9,
		OP_SETX = 5'd10,
		OP_BEX  = 5'd11,
		OP_IN   = 5'd12
	} opcode_e;

	// Same values as the alu_func field of R-type words
	typedef enum logic [3:0] {
		ALU_ADD = 4'd0,
		ALU_SUB = 4'd1,
		ALU_AND = 4'd2,
		ALU_OR  = 4'd3,
		ALU_SLL = 4'd4,
		ALU_SRA = 4'd5,
		ALU_SLT = 4'd6
	} alu_op_e;

	typedef enum logic [1:0] {
		FWD_REG = 2'd0,
		FWD_MEM = 2'd1,
		FWD_WB  = 2'd2
	} fwd_sel_e;

	//////////////////////////////////////////////////////////////////////
	// Pipeline state
	//////////////////////////////////////////////////////////////////////

	// rs and rt name the two register reads, whichever fields they came from
	typedef struct packed {
		opcode_e          opcode;
		alu_op_e          alu_op;
		logic [REG_W-1:0] rd;
		logic [REG_W-1:0] rs;
		logic [REG_W-1:0] rt;
		logic [4:0]       shamt;
		logic             uses_rs;
		logic             uses_rt;
		logic             writes_reg;
		logic             mem_read;
		logic             mem_write;
		logic             use_imm;
		logic             is_branch;
		logic             is_jump;
	} ctrl_t;

	// All zero is an add into r0 with no side effects
	localparam ctrl_t CTRL_NOP = '0;

	typedef struct packed {
		logic [XLEN-1:0] pc_next;
		logic [XLEN-1:0] instr;
		logic            valid;
	} fd_reg_t;

	typedef struct packed {
		ctrl_t           ctrl;
		logic [XLEN-1:0] pc_next;
		logic [XLEN-1:0] a;
		logic [XLEN-1:0] b;
		logic [XLEN-1:0] imm;
	} de_reg_t;

	typedef struct packed {
		ctrl_t           ctrl;
		logic [XLEN-1:0] pc_next;
		logic [XLEN-1:0] result;
		logic [XLEN-1:0] store_data;
	} em_reg_t;

	typedef struct packed {
		ctrl_t           ctrl;
		logic [XLEN-1:0] pc_next;
		logic [XLEN-1:0] result;
		logic [XLEN-1:0] load_data;
	} mw_reg_t;

endpackage

//--- source/hazard_unit.sv
`timescale 1ns/1ps

module hazard_unit import cpu_pkg::*; (
	input  fd_reg_t  fd,
	input  ctrl_t    de_ctrl,
	input  ctrl_t    em_ctrl,
	input  ctrl_t    mw_ctrl,
	output fwd_sel_e fwd_a,
	output fwd_sel_e fwd_b,
	output fwd_sel_e fwd_store,
	output logic     stall
);

	opcode_e fd_op;
	logic [REG_W-1:0] fd_src_a, fd_src_b;
	logic fd_use_a, fd_use_b;

	// True when stage c will write register src
	function automatic logic writes(input ctrl_t c, input logic [REG_W-1:0] src);
		return c.writes_reg && c.rd != '0 && c.rd == src;
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Execute forwarding
	//////////////////////////////////////////////////////////////////////

	// Memory stage wins; a load there only has its address so far
	assign fwd_a = (de_ctrl.uses_rs && writes(em_ctrl, de_ctrl.rs) && !em_ctrl.mem_read)
		? FWD_MEM
		: (de_ctrl.uses_rs && writes(mw_ctrl, de_ctrl.rs)) ? FWD_WB : FWD_REG;

	assign fwd_b = (de_ctrl.uses_rt && writes(em_ctrl, de_ctrl.rt) && !em_ctrl.mem_read)
		? FWD_MEM
		: (de_ctrl.uses_rt && writes(mw_ctrl, de_ctrl.rt)) ? FWD_WB : FWD_REG;

	// Store data picked up late from writeback, covers a load right before a store
	assign fwd_store = (em_ctrl.mem_write && writes(mw_ctrl, em_ctrl.rt)) ? FWD_WB : FWD_REG;

	//////////////////////////////////////////////////////////////////////
	// Load-use stall
	//////////////////////////////////////////////////////////////////////

	assign fd_op = opcode_e'(fd.instr[31:27]);

	// Registers the decoding instruction needs in execute
	always_comb begin
		fd_src_a = fd.instr[21:17];
		fd_src_b = fd.instr[16:12];
		fd_use_a = 1'b0;
		fd_use_b = 1'b0;
		case (fd_op)
			OP_ALU: begin
				fd_use_a = 1'b1;
				fd_use_b = 1'b1;
			end
			OP_ADDI, OP_LW, OP_SW: fd_use_a = 1'b1;
			OP_BEQ, OP_BNE, OP_BLT: begin
				fd_src_a = fd.instr[26:22];
				fd_src_b = fd.instr[21:17];
				fd_use_a = 1'b1;
				fd_use_b = 1'b1;
			end
			OP_JR: begin
				fd_src_a = fd.instr[26:22];
				fd_use_a = 1'b1;
			end
			default: ;
		endcase
	end

	assign stall = fd.valid && de_ctrl.mem_read &&
		((fd_use_a && writes(de_ctrl, fd_src_a)) || (fd_use_b && writes(de_ctrl, fd_src_b)));

endmodule

//--- source/instr_decoder.sv
`timescale 1ns/1ps

module instr_decoder import cpu_pkg::*; (
	input  logic [XLEN-1:0] instr,
	output ctrl_t           ctrl,
	output logic [XLEN-1:0] imm
);

	opcode_e op;

	assign op = opcode_e'(instr[31:27]);

	always_comb begin
		ctrl        = CTRL_NOP;
		ctrl.opcode = op;
		ctrl.rd     = instr[26:22];
		ctrl.shamt  = instr[11:7];
		imm         = {{(XLEN-17){instr[16]}}, instr[16:0]};

		case (op)
			OP_ALU: begin
				ctrl.rs         = instr[21:17];
				ctrl.rt         = instr[16:12];
				ctrl.uses_rs    = 1'b1;
				ctrl.uses_rt    = 1'b1;
				ctrl.writes_reg = 1'b1;
				case (instr[6:2])
					5'd0: ctrl.alu_op = ALU_ADD;
					5'd1: ctrl.alu_op = ALU_SUB;
					5'd2: ctrl.alu_op = ALU_AND;
					5'd3: ctrl.alu_op = ALU_OR;
					5'd4: ctrl.alu_op = ALU_SLL;
					5'd5: ctrl.alu_op = ALU_SRA;
					5'd6: ctrl.alu_op = ALU_SLT;
					default: ctrl = CTRL_NOP;
				endcase
			end
			OP_ADDI, OP_LW: begin
				ctrl.rs         = instr[21:17];
				ctrl.uses_rs    = 1'b1;
				ctrl.writes_reg = 1'b1;
				ctrl.use_imm    = 1'b1;
				ctrl.mem_read   = (op == OP_LW);
			end
			OP_SW: begin
				// Base in rs, data comes from the rd field
				ctrl.rs        = instr[21:17];
				ctrl.rt        = instr[26:22];
				ctrl.uses_rs   = 1'b1;
				ctrl.uses_rt   = 1'b1;
				ctrl.use_imm   = 1'b1;
				ctrl.mem_write = 1'b1;
			end
			OP_BEQ, OP_BNE, OP_BLT: begin
				ctrl.rs        = instr[26:22];
				ctrl.rt        = instr[21:17];
				ctrl.uses_rs   = 1'b1;
				ctrl.uses_rt   = 1'b1;
				ctrl.alu_op    = ALU_SUB;
				ctrl.is_branch = 1'b1;
			end
			OP_J, OP_JAL, OP_BEX, OP_SETX: begin
				imm             = {{(XLEN-27){1'b0}}, instr[26:0]};
				ctrl.is_jump    = (op != OP_SETX);
				ctrl.writes_reg = (op == OP_JAL);
				ctrl.rd         = (op == OP_JAL) ? LINK_REG : '0;
			end
			OP_JR: begin
				ctrl.rs      = instr[26:22];
				ctrl.uses_rs = 1'b1;
				ctrl.is_jump = 1'b1;
			end
			OP_IN:   ctrl.writes_reg = 1'b1;
			default: ctrl = CTRL_NOP;
		endcase
	end

endmodule

//--- source/processor.sv
`timescale 1ns/1ps

module processor import cpu_pkg::*; (
	input  logic               clock,
	input  logic               rst_n,
	input  logic               run,
	input  logic               prog_we,
	input  logic [IMEM_AW-1:0] prog_addr,
	input  logic [XLEN-1:0]    prog_data,
	input  logic [7:0]         in_data,
	output logic               mem_wr,
	output logic [DMEM_AW-1:0] mem_addr,
	output logic [XLEN-1:0]    mem_wdata,
	output logic               out_valid,
	output logic [XLEN-1:0]    out_data
);

	logic [XLEN-1:0] imem [IMEM_WORDS];
	logic [XLEN-1:0] dmem [DMEM_WORDS];

	logic [XLEN-1:0] pc;
	logic [XLEN-1:0] status;
	fd_reg_t fd;
	de_reg_t de;
	em_reg_t em;
	mw_reg_t mw;

	ctrl_t dec_ctrl;
	logic [XLEN-1:0] dec_imm;
	logic [XLEN-1:0] rd_data_a, rd_data_b;
	fwd_sel_e fwd_a, fwd_b, fwd_store;
	logic stall;

	logic [XLEN-1:0] op_a, op_b, alu_b, alu_result, ex_result;
	logic less_than, not_equal;
	logic branch_taken, jump_taken, redirect;
	logic [XLEN-1:0] target;
	logic [XLEN-1:0] wb_data;

	// Operand source chosen by the hazard unit
	function automatic logic [XLEN-1:0] fwd_pick(input fwd_sel_e sel,
			input logic [XLEN-1:0] from_reg, input logic [XLEN-1:0] from_mem,
			input logic [XLEN-1:0] from_wb);
		case (sel)
			FWD_MEM: return from_mem;
			FWD_WB:  return from_wb;
			default: return from_reg;
		endcase
	endfunction

	// Loader writes only while the core is idle
	always_ff @(posedge clock) begin
		if (prog_we && !run)
			imem[prog_addr] <= prog_data;
	end

	instr_decoder instr_decoder_inst (
		.instr (fd.instr),
		.ctrl  (dec_ctrl),
		.imm   (dec_imm)
	);

	reg_file reg_file_inst (
		.clock     (clock),
		.rst_n     (rst_n),
		.rd_addr_a (dec_ctrl.rs),
		.rd_addr_b (dec_ctrl.rt),
		.rd_data_a (rd_data_a),
		.rd_data_b (rd_data_b),
		.wr_en     (mw.ctrl.writes_reg),
		.wr_addr   (mw.ctrl.rd),
		.wr_data   (wb_data)
	);

	hazard_unit hazard_unit_inst (
		.fd        (fd),
		.de_ctrl   (de.ctrl),
		.em_ctrl   (em.ctrl),
		.mw_ctrl   (mw.ctrl),
		.fwd_a     (fwd_a),
		.fwd_b     (fwd_b),
		.fwd_store (fwd_store),
		.stall     (stall)
	);

	//////////////////////////////////////////////////////////////////////
	// Execute
	//////////////////////////////////////////////////////////////////////

	assign op_a  = fwd_pick(fwd_a, de.a, em.result, wb_data);
	assign op_b  = fwd_pick(fwd_b, de.b, em.result, wb_data);
	assign alu_b = de.ctrl.use_imm ? de.imm : op_b;

	alu alu_inst (
		.operand_a (op_a),
		.operand_b (alu_b),
		.alu_op    (de.ctrl.alu_op),
		.shamt     (de.ctrl.shamt),
		.result    (alu_result),
		.less_than (less_than),
		.not_equal (not_equal)
	);

	always_comb begin
		case (de.ctrl.opcode)
			OP_IN:   ex_result = {{(XLEN-8){1'b0}}, in_data};
			OP_JAL:  ex_result = de.pc_next;
			default: ex_result = alu_result;
		endcase
	end

	// Branch and jump resolution
	always_comb begin
		case (de.ctrl.opcode)
			OP_BEQ:  branch_taken = de.ctrl.is_branch && !not_equal;
			OP_BNE:  branch_taken = de.ctrl.is_branch && not_equal;
			OP_BLT:  branch_taken = de.ctrl.is_branch && less_than;
			default: branch_taken = 1'b0;
		endcase
	end

	assign jump_taken = de.ctrl.is_jump && (de.ctrl.opcode != OP_BEX || status != '0);
	assign redirect   = branch_taken || jump_taken;

	always_comb begin
		if (branch_taken)
			target = de.pc_next + de.imm;
		else if (de.ctrl.opcode == OP_JR)
			target = op_a;
		else
			target = de.imm;
	end

	//////////////////////////////////////////////////////////////////////
	// Memory and writeback
	//////////////////////////////////////////////////////////////////////

	assign mem_wr    = run && em.ctrl.mem_write;
	assign mem_addr  = em.result[DMEM_AW-1:0];
	assign mem_wdata = (fwd_store == FWD_WB) ? wb_data : em.store_data;

	always_ff @(posedge clock) begin
		if (mem_wr)
			dmem[mem_addr] <= mem_wdata;
	end

	always_comb begin
		if (mw.ctrl.opcode == OP_JAL)
			wb_data = mw.pc_next;
		else if (mw.ctrl.mem_read)
			wb_data = mw.load_data;
		else
			wb_data = mw.result;
	end

	// Output port latch
	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n)
			out_valid <= 1'b0;
		else
			out_valid <= mem_wr && mem_addr == DMEM_AW'(IO_ADDR);
	end

	always_ff @(posedge clock) begin
		if (mem_wr && mem_addr == DMEM_AW'(IO_ADDR))
			out_data <= mem_wdata;
	end

	//////////////////////////////////////////////////////////////////////
	// PC, status and pipeline registers
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			pc     <= '0;
			status <= '0;
			fd     <= '0;
			de     <= '0;
			em     <= '0;
			mw     <= '0;
		end else if (run) begin
			if (de.ctrl.opcode == OP_SETX)
				status <= de.imm;

			if (redirect) begin
				// Drop the two younger instructions
				pc <= target;
				fd <= '0;
				de <= '0;
			end else if (stall) begin
				de <= '0;
			end else begin
				pc <= pc + 32'd1;
				fd <= '{pc_next: pc + 32'd1, instr: imem[pc[IMEM_AW-1:0]], valid: 1'b1};
				de <= '{ctrl: fd.valid ? dec_ctrl : CTRL_NOP, pc_next: fd.pc_next,
					a: rd_data_a, b: rd_data_b, imm: dec_imm};
			end

			em <= '{ctrl: de.ctrl, pc_next: de.pc_next, result: ex_result, store_data: op_b};
			mw <= '{ctrl: em.ctrl, pc_next: em.pc_next, result: em.result,
				load_data: dmem[mem_addr]};
		end
	end

endmodule

//--- source/reg_file.sv
`timescale 1ns/1ps

module reg_file import cpu_pkg::*; (
	input  logic             clock,
	input  logic             rst_n,
	input  logic [REG_W-1:0] rd_addr_a,
	input  logic [REG_W-1:0] rd_addr_b,
	output logic [XLEN-1:0]  rd_data_a,
	output logic [XLEN-1:0]  rd_data_b,
	input  logic             wr_en,
	input  logic [REG_W-1:0] wr_addr,
	input  logic [XLEN-1:0]  wr_data
);

	logic [XLEN-1:0] regs [1:31];

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 1; i < 32; i++)
				regs[i] <= '0;
		end else if (wr_en && wr_addr != '0) begin
			regs[wr_addr] <= wr_data;
		end
	end

	// r0 is hardwired, a write in the same cycle passes straight through
	always_comb begin
		if (rd_addr_a == '0)
			rd_data_a = '0;
		else if (wr_en && wr_addr == rd_addr_a)
			rd_data_a = wr_data;
		else
			rd_data_a = regs[rd_addr_a];

		if (rd_addr_b == '0)
			rd_data_b = '0;
		else if (wr_en && wr_addr == rd_addr_b)
			rd_data_b = wr_data;
		else
			rd_data_b = regs[rd_addr_b];
	end

endmodule
